// ==== Bender.yml ====
package:
  name: arcade_mem

sources:
  - hdl/mem_bus_pkg.sv
  - hdl/mem_map_pkg.sv
  - hdl/mem_port_if.sv
  - hdl/rom_dwnld.sv
  - hdl/rom_slots.sv
  - hdl/mem_port_arb.sv
  - hdl/arcade_mem_top.sv
  - target: simulation
    files:
      - sim/sdram_model.sv
      - sim/tb_arcade_mem.sv

// ==== arcade_mem.f ====
hdl/mem_bus_pkg.sv
hdl/mem_map_pkg.sv
hdl/mem_port_if.sv
hdl/rom_dwnld.sv
hdl/rom_slots.sv
hdl/mem_port_arb.sv
hdl/arcade_mem_top.sv
sim/sdram_model.sv
sim/tb_arcade_mem.sv

// ==== hdl/arcade_mem_top.sv ====
module arcade_mem_top import mem_bus_pkg::*, mem_map_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    // ROM download
    input  logic              downloading,
    input  logic [24:0]       ioctl_addr,
    input  logic [7:0]        ioctl_dout,
    input  logic              ioctl_wr,
    output logic [1:0]        game_id,
    output logic              fd1089_en,
    output logic              fd1094_en,
    output logic              dec_type,
    output logic              dwnld_busy,

    input  logic [CPU_AW-1:0] main_addr,
    input  logic              main_cs,
    output word_t             main_data,
    output logic              main_ok,

    input  logic [CPU_AW-1:0] sub_addr,
    input  logic              srom_cs,
    output word_t             srom_data,
    output logic              srom_ok,

    input  logic [SND_AW-1:0] snd_addr,
    input  logic              snd_cs,
    output logic [7:0]        snd_data,
    output logic              snd_ok,

    input  logic [PCM_AW-1:0] pcm_addr,
    input  logic              pcm_cs,
    output logic [7:0]        pcm_data,
    output logic              pcm_ok,

    // SDRAM controller
    output waddr_t            mem_addr,
    output logic              mem_rd,
    output logic              mem_wr,
    output word_t             mem_din,
    input  logic              mem_ack,
    input  logic              mem_rdy,
    input  word_t             mem_data
);

    waddr_t  prog_addr;
    word_t   prog_data;
    logic    prog_we;
    logic    prog_ack;
    header_t header;

    mem_port_if bank0_if ();
    mem_port_if bank1_if ();

    assign game_id   = header.game_id;
    assign fd1089_en = header.fd1089_en;
    assign fd1094_en = header.fd1094_en;
    assign dec_type  = header.dec_type;

    rom_dwnld u_dwnld (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_we     (prog_we),
        .prog_ack    (prog_ack),
        .header      (header),
        .dwnld_busy  (dwnld_busy)
    );

    // CPU code, 16-bit words
    rom_slots #(
        .data_t  (word_t),
        .AW0     (CPU_AW),
        .AW1     (CPU_AW),
        .OFFSET0 (MROM_OFFSET),
        .OFFSET1 (SROM_OFFSET)
    ) u_bank0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .slot0_addr (main_addr),
        .slot0_cs   (main_cs),
        .slot0_data (main_data),
        .slot0_ok   (main_ok),
        .slot1_addr (sub_addr),
        .slot1_cs   (srom_cs),
        .slot1_data (srom_data),
        .slot1_ok   (srom_ok),
        .mem        (bank0_if.requester)
    );

    // Sound side, byte clients
    rom_slots #(
        .data_t  (logic [7:0]),
        .AW0     (SND_AW),
        .AW1     (PCM_AW),
        .OFFSET0 (SND_OFFSET),
        .OFFSET1 (PCM_OFFSET)
    ) u_bank1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .slot0_addr (snd_addr),
        .slot0_cs   (snd_cs),
        .slot0_data (snd_data),
        .slot0_ok   (snd_ok),
        .slot1_addr (pcm_addr),
        .slot1_cs   (pcm_cs),
        .slot1_data (pcm_data),
        .slot1_ok   (pcm_ok),
        .mem        (bank1_if.requester)
    );

    mem_port_arb u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_we   (prog_we),
        .prog_ack  (prog_ack),
        .bank0     (bank0_if.arbiter),
        .bank1     (bank1_if.arbiter),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_din   (mem_din),
        .mem_ack   (mem_ack),
        .mem_rdy   (mem_rdy),
        .mem_data  (mem_data)
    );

endmodule

// ==== hdl/mem_bus_pkg.sv ====
package mem_bus_pkg;

    typedef logic [15:0] word_t;   // SDRAM word
    typedef logic [21:0] waddr_t;  // Word address, 8 MB space

    // Game settings carried in the first bytes of the download
    typedef struct packed {
        logic [1:0] game_id;
        logic       fd1089_en;
        logic       fd1094_en;
        logic       dec_type;
    } header_t;

    // Header bytes are parsed but never stored
    localparam int HEADER_LEN = 16;

endpackage

// ==== hdl/mem_map_pkg.sv ====
package mem_map_pkg;

    // Word offsets of each ROM region in the linear download image
    // Bank 0 holds the CPU code, bank 1 the sound side
    localparam logic [21:0] MROM_OFFSET = 22'h00_0000; // Main CPU ROM
    localparam logic [21:0] SROM_OFFSET = 22'h04_0000; // Sub CPU ROM
    localparam logic [21:0] SND_OFFSET  = 22'h08_0000; // Sound CPU ROM
    localparam logic [21:0] PCM_OFFSET  = 22'h09_0000; // ADPCM samples

    // Slot address widths as seen by the clients

    // 68000 style word address, 512 kB
    localparam int CPU_AW = 18;

    // Z80 byte address, 64 kB
    localparam int SND_AW = 16;

    // PCM byte address, 512 kB
    localparam int PCM_AW = 19;

endpackage

// ==== hdl/mem_port_arb.sv ====
module mem_port_arb import mem_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  waddr_t      prog_addr,
    input  word_t       prog_data,
    input  logic        prog_we,
    output logic        prog_ack,

    mem_port_if.arbiter bank0,
    mem_port_if.arbiter bank1,

    output waddr_t      mem_addr,
    output logic        mem_rd,
    output logic        mem_wr,
    output word_t       mem_din,
    input  logic        mem_ack,
    input  logic        mem_rdy,
    input  word_t       mem_data
);

    typedef enum logic [1:0] {OWN_WR, OWN_B0, OWN_B1} owner_e;

    logic   wr_pend;
    waddr_t wr_addr;
    word_t  wr_data;
    logic   active;   // One external transaction at a time
    owner_e owner;
    logic   grant_wr;
    logic   grant_b0;
    logic   grant_b1;

    // Fixed priority, download first
    assign grant_wr = !active && wr_pend;
    assign grant_b0 = !active && !wr_pend && bank0.rd;
    assign grant_b1 = !active && !wr_pend && !bank0.rd && bank1.rd;

    assign prog_ack   = mem_ack && mem_wr;
    assign bank0.ack  = mem_ack && mem_rd && (owner == OWN_B0);
    assign bank1.ack  = mem_ack && mem_rd && (owner == OWN_B1);
    assign bank0.rdy  = mem_rdy && active && (owner == OWN_B0);
    assign bank1.rdy  = mem_rdy && active && (owner == OWN_B1);
    assign bank0.data = mem_data;
    assign bank1.data = mem_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pend <= 1'b0;
            active  <= 1'b0;
            owner   <= OWN_WR;
            mem_rd  <= 1'b0;
            mem_wr  <= 1'b0;
        end else begin
            if (prog_we) begin
                wr_pend <= 1'b1;
            end else if (grant_wr) begin
                wr_pend <= 1'b0;
            end

            if (grant_wr || grant_b0 || grant_b1) begin
                active <= 1'b1;
                mem_wr <= grant_wr;
                mem_rd <= !grant_wr;
                owner  <= grant_wr ? OWN_WR : (grant_b0 ? OWN_B0 : OWN_B1);
            end else if (active) begin
                if (mem_ack) begin
                    mem_rd <= 1'b0;
                    mem_wr <= 1'b0;
                    if (owner == OWN_WR) begin
                        active <= 1'b0;  // Writes end at ack
                    end
                end
                if (mem_rdy && owner != OWN_WR) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prog_we) begin
            wr_addr <= prog_addr;
            wr_data <= prog_data;
        end
        if (grant_wr) begin
            mem_addr <= wr_addr;
            mem_din  <= wr_data;
        end else if (grant_b0) begin
            mem_addr <= bank0.addr;
        end else if (grant_b1) begin
            mem_addr <= bank1.addr;
        end
    end

endmodule

// ==== hdl/mem_port_if.sv ====
interface mem_port_if import mem_bus_pkg::*; ();

    waddr_t addr;
    logic   rd;     // Held with addr stable until ack
    logic   ack;    // Request taken, one cycle
    logic   rdy;    // Data valid, one cycle
    word_t  data;

    // Read client side, one per slot bank
    modport requester (
        output addr,
        output rd,
        input  ack,
        input  rdy,
        input  data
    );

    modport arbiter (
        input  addr,
        input  rd,
        output ack,
        output rdy,
        output data
    );

endinterface

// ==== hdl/rom_dwnld.sv ====
module rom_dwnld import mem_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    output waddr_t      prog_addr,
    output word_t       prog_data,
    output logic        prog_we,
    input  logic        prog_ack,
    output header_t     header,
    output logic        dwnld_busy
);

    logic        in_header;
    logic [24:0] data_off;   // Byte offset past the header
    logic [7:0]  hi_byte;
    logic        wr_wait;    // Last word not yet taken by the port

    assign in_header = ioctl_addr < 25'(HEADER_LEN);
    assign data_off  = ioctl_addr - 25'(HEADER_LEN);

    // Busy also covers the gap between the last byte and its memory ack
    assign dwnld_busy = downloading || prog_we || wr_wait;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            header  <= '0;
            prog_we <= 1'b0;
            wr_wait <= 1'b0;
        end else begin
            // Odd byte completes a word
            prog_we <= ioctl_wr && !in_header && data_off[0];

            if (ioctl_wr && in_header) begin
                case (ioctl_addr[3:0])
                    4'd0: begin
                        header.dec_type  <= ioctl_dout[0];
                        header.fd1089_en <= ioctl_dout[1];
                        header.fd1094_en <= ioctl_dout[2];
                    end
                    4'd1: header.game_id <= ioctl_dout[1:0];
                    default: ;
                endcase
            end

            if (prog_we) begin
                wr_wait <= 1'b1;
            end else if (prog_ack) begin
                wr_wait <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl_wr && !in_header) begin
            if (!data_off[0]) begin
                hi_byte <= ioctl_dout;  // Even byte goes to the top half
            end else begin
                prog_data <= {hi_byte, ioctl_dout};
                prog_addr <= data_off[22:1];
            end
        end
    end

endmodule

// ==== hdl/rom_slots.sv ====
module rom_slots import mem_bus_pkg::*; #(
    parameter type    data_t  = word_t,
    parameter int     AW0     = 18,
    parameter int     AW1     = 18,
    parameter waddr_t OFFSET0 = '0,
    parameter waddr_t OFFSET1 = '0
) (
    input  logic           clk,
    input  logic           rst_n,

    input  logic [AW0-1:0] slot0_addr,
    input  logic           slot0_cs,
    output data_t          slot0_data,
    output logic           slot0_ok,

    input  logic [AW1-1:0] slot1_addr,
    input  logic           slot1_cs,
    output data_t          slot1_data,
    output logic           slot1_ok,

    mem_port_if.requester  mem
);

    // Byte clients address bytes, bit 0 picks the half of the word
    localparam bit BYTE_WIDE = ($bits(data_t) == 8);

    waddr_t     cur_addr [2];  // Requested word incl. region offset
    waddr_t     tag [2];
    word_t      cache [2];
    data_t      dout [2];
    logic [1:0] cs;
    logic [1:0] lo;
    logic [1:0] hit;
    logic [1:0] miss;
    logic [1:0] valid;
    logic [1:0] ok;
    logic       busy;
    logic       rd_q;
    logic       owner;
    logic       pick;
    waddr_t     req_addr;

    function automatic data_t sel_data(word_t w, logic low);
        if (BYTE_WIDE) begin
            return data_t'(low ? w[7:0] : w[15:8]);
        end else begin
            return data_t'(w);
        end
    endfunction

    always_comb begin
        cs = {slot1_cs, slot0_cs};
        lo = {slot1_addr[0], slot0_addr[0]};
        cur_addr[0] = OFFSET0 + (BYTE_WIDE ? waddr_t'(slot0_addr >> 1) : waddr_t'(slot0_addr));
        cur_addr[1] = OFFSET1 + (BYTE_WIDE ? waddr_t'(slot1_addr >> 1) : waddr_t'(slot1_addr));
        for (int i = 0; i < 2; i++) begin
            hit[i] = valid[i] && (tag[i] == cur_addr[i]);
        end
        miss = cs & ~hit;
        pick = !miss[0];   // Slot 0 first
    end

    assign mem.addr   = req_addr;
    assign mem.rd     = rd_q;
    assign slot0_data = dout[0];
    assign slot1_data = dout[1];
    assign slot0_ok   = ok[0];
    assign slot1_ok   = ok[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            rd_q  <= 1'b0;
            owner <= 1'b0;
            valid <= '0;
            ok    <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                ok[i] <= cs[i] && hit[i];
            end
            if (!busy) begin
                if (|miss) begin
                    busy        <= 1'b1;
                    rd_q        <= 1'b1;
                    owner       <= pick;
                    valid[pick] <= 1'b0;
                end
            end else begin
                if (mem.ack) begin
                    rd_q <= 1'b0;
                end
                if (mem.rdy) begin
                    busy         <= 1'b0;
                    rd_q         <= 1'b0;
                    valid[owner] <= 1'b1;
                    // Address may have moved while the fetch was in flight
                    ok[owner]    <= cs[owner] && (tag[owner] == cur_addr[owner]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            dout[i] <= sel_data(cache[i], lo[i]);
        end
        if (!busy && |miss) begin
            req_addr  <= cur_addr[pick];
            tag[pick] <= cur_addr[pick];
        end
        if (busy && mem.rdy) begin
            cache[owner] <= mem.data;
            dout[owner]  <= sel_data(mem.data, lo[owner]); // Bypass the cache
        end
    end

endmodule

// ==== sim/sdram_model.sv ====
module sdram_model import mem_bus_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  waddr_t mem_addr,
    input  logic   mem_rd,
    input  logic   mem_wr,
    input  word_t  mem_din,
    output logic   mem_ack,
    output logic   mem_rdy,
    output word_t  mem_data
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {IDLE, WAIT_ACK, WAIT_RDY} state_e;

    word_t  store [waddr_t];  // Only words written by the download
    int     wr_count;
    state_e state;
    int     delay;
    waddr_t addr_q;
    logic   is_rd;

    // Unwritten words read back as a pattern of their address
    function automatic word_t peek(waddr_t a);
        if (store.exists(a)) begin
            return store[a];
        end
        return a[15:0] ^ 16'ha5c3;
    endfunction

    initial begin
        mem_ack  = 1'b0;
        mem_rdy  = 1'b0;
        mem_data = '0;
        wr_count = 0;
        delay    = 0;
        state    = IDLE;
        forever begin
            @(posedge clk);
            #5;
            mem_ack = 1'b0;  // Both strobes last one cycle
            mem_rdy = 1'b0;
            case (state)
                IDLE: begin
                    if (rst_n && (mem_rd || mem_wr)) begin
                        addr_q = mem_addr;
                        is_rd  = mem_rd;
                        delay  = $urandom_range(3);
                        state  = WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (delay == 0) begin
                        mem_ack = 1'b1;
                        if (is_rd) begin
                            delay = $urandom_range(4);
                            state = WAIT_RDY;
                        end else begin
                            store[addr_q] = mem_din;  // Write is done at ack
                            wr_count++;
                            state = IDLE;
                        end
                    end else begin
                        delay--;
                    end
                end
                default: begin
                    if (delay == 0) begin
                        mem_rdy  = 1'b1;
                        mem_data = peek(addr_q);
                        state    = IDLE;
                    end else begin
                        delay--;
                    end
                end
            endcase
        end
    end

endmodule

// ==== sim/tb_arcade_mem.sv ====
module tb_arcade_mem import mem_bus_pkg::*, mem_map_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_WORDS = 64;
    localparam int N_BYTES = HEADER_LEN + 2 * N_WORDS;
    localparam int N_READS = 16;  // Per slot and per phase
    localparam int N_OPS   = N_BYTES + 8 * N_READS + 4;

    logic              clk;
    logic              rst_n;
    logic              downloading;
    logic [24:0]       ioctl_addr;
    logic [7:0]        ioctl_dout;
    logic              ioctl_wr;
    logic [1:0]        game_id;
    logic              fd1089_en;
    logic              fd1094_en;
    logic              dec_type;
    logic              dwnld_busy;
    logic [CPU_AW-1:0] main_addr;
    logic              main_cs;
    word_t             main_data;
    logic              main_ok;
    logic [CPU_AW-1:0] sub_addr;
    logic              srom_cs;
    word_t             srom_data;
    logic              srom_ok;
    logic [SND_AW-1:0] snd_addr;
    logic              snd_cs;
    logic [7:0]        snd_data;
    logic              snd_ok;
    logic [PCM_AW-1:0] pcm_addr;
    logic              pcm_cs;
    logic [7:0]        pcm_data;
    logic              pcm_ok;
    waddr_t            mem_addr;
    logic              mem_rd;
    logic              mem_wr;
    word_t             mem_din;
    logic              mem_ack;
    logic              mem_rdy;
    word_t             mem_data;

    word_t       image [waddr_t];  // Reference copy of the downloaded words
    header_t     exp_hdr;
    logic [21:0] last_addr [4];
    logic        single_reader;  // Only one slot can miss, so each mem_rd is its fetch
    string       data_name [4] = '{"main_data", "srom_data", "snd_data", "pcm_data"};
    string       ok_name [4]   = '{"main_ok", "srom_ok", "snd_ok", "pcm_ok"};

    arcade_mem_top i_dut (.*);

    sdram_model i_sdram (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t expected_word(waddr_t a);
        if (image.exists(a)) begin
            return image[a];
        end
        return a[15:0] ^ 16'ha5c3;
    endfunction

    // Region offset plus word address, byte slots drop bit 0
    function automatic waddr_t word_addr(int s, logic [21:0] a);
        case (s)
            0: return MROM_OFFSET + a;
            1: return SROM_OFFSET + a;
            2: return SND_OFFSET + (a >> 1);
            default: return PCM_OFFSET + (a >> 1);
        endcase
    endfunction

    // Slots 2 and 3 take byte addresses, even byte is the high half
    function automatic logic [15:0] slot_model(int s, logic [21:0] a);
        word_t w;
        w = expected_word(word_addr(s, a));
        if (s < 2) begin
            return w;
        end
        return {8'h00, a[0] ? w[7:0] : w[15:8]};
    endfunction

    function automatic logic [21:0] random_addr(int s);
        int width;
        if (s == 0) begin
            return 22'($urandom_range(2 * N_WORDS - 1));  // Half inside the image
        end
        width = (s == 1) ? CPU_AW : ((s == 2) ? SND_AW : PCM_AW);
        return 22'($urandom & ((32'd1 << width) - 1));
    endfunction

    function automatic logic ok_of(int s);
        case (s)
            0: return main_ok;
            1: return srom_ok;
            2: return snd_ok;
            default: return pcm_ok;
        endcase
    endfunction

    function automatic logic [15:0] data_of(int s);
        case (s)
            0: return main_data;
            1: return srom_data;
            2: return {8'h00, snd_data};
            default: return {8'h00, pcm_data};
        endcase
    endfunction

    task automatic drive_slot(int s, logic [21:0] a, logic cs);
        case (s)
            0: begin
                main_addr = a[CPU_AW-1:0];
                main_cs   = cs;
            end
            1: begin
                sub_addr = a[CPU_AW-1:0];
                srom_cs  = cs;
            end
            2: begin
                snd_addr = a[SND_AW-1:0];
                snd_cs   = cs;
            end
            default: begin
                pcm_addr = a[PCM_AW-1:0];
                pcm_cs   = cs;
            end
        endcase
    endtask

    task automatic compare(string name, logic [21:0] exp, logic [21:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic verify_header();
        compare("game_id", 16'(exp_hdr.game_id), 16'(game_id));
        compare("fd1089_en", 16'(exp_hdr.fd1089_en), 16'(fd1089_en));
        compare("fd1094_en", 16'(exp_hdr.fd1094_en), 16'(fd1094_en));
        compare("dec_type", 16'(exp_hdr.dec_type), 16'(dec_type));
    endtask

    task automatic send_byte(int a, logic [7:0] d);
        @(posedge clk);
        #5;
        ioctl_addr = 25'(a);
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #5;
        ioctl_wr = 1'b0;
        if (a == 0) begin
            exp_hdr.dec_type  = d[0];
            exp_hdr.fd1089_en = d[1];
            exp_hdr.fd1094_en = d[2];
        end else if (a == 1) begin
            exp_hdr.game_id = d[1:0];
        end
        verify_header();  // One cycle after the write
        compare("dwnld_busy", 16'd1, 16'(dwnld_busy));
        repeat (3) @(posedge clk);  // Slow pacing, one write in flight
    endtask

    task automatic read_slot(int s);
        logic [21:0] a;
        a = random_addr(s);
        if ($urandom_range(3) == 0) begin
            a = last_addr[s] ^ 22'(s >= 2);  // Same word, other byte on bank 1
        end
        last_addr[s] = a;
        @(posedge clk);
        #5;
        drive_slot(s, a, 1'b1);
        do begin
            @(posedge clk);
            #5;
            if (single_reader && mem_rd) begin
                compare("mem_addr", word_addr(s, a), mem_addr);
            end
        end while (!ok_of(s));
        compare(data_name[s], slot_model(s, a), data_of(s));
    endtask

    // Drop cs for a cycle, then the cached word must come back at once
    task automatic recheck_cached(int s);
        @(posedge clk);
        #5;
        drive_slot(s, last_addr[s], 1'b0);
        @(posedge clk);
        #5;
        compare(ok_name[s], 16'd0, 16'(ok_of(s)));
        drive_slot(s, last_addr[s], 1'b1);
        @(posedge clk);
        #5;
        compare(ok_name[s], 16'd1, 16'(ok_of(s)));
        compare(data_name[s], slot_model(s, last_addr[s]), data_of(s));
        repeat (2) @(posedge clk);
        #5;
        compare("mem_rd", 16'd0, 16'(mem_rd));
    endtask

    initial begin
        logic [7:0] hi;
        logic [7:0] lo;
        void'($urandom(32'h5b7b_7c2f));
        rst_n         = 1'b0;
        downloading   = 1'b0;
        ioctl_addr    = '0;
        ioctl_dout    = '0;
        ioctl_wr      = 1'b0;
        exp_hdr       = '0;
        single_reader = 1'b1;
        for (int s = 0; s < 4; s++) begin
            last_addr[s] = '0;
            drive_slot(s, '0, 1'b0);
        end
        repeat (16) @(posedge clk);
        compare("mem_rd", 16'd0, 16'(mem_rd));
        compare("mem_wr", 16'd0, 16'(mem_wr));
        compare("dwnld_busy", 16'd0, 16'(dwnld_busy));
        compare("slot ok flags", 16'd0, 16'({main_ok, srom_ok, snd_ok, pcm_ok}));
        verify_header();
        #5;
        rst_n = 1'b1;

        @(posedge clk);
        #5;
        downloading = 1'b1;
        for (int i = 0; i < HEADER_LEN; i++) begin
            send_byte(i, 8'($urandom));
        end
        compare("header writes", 16'd0, 16'(i_sdram.wr_count));
        for (int w = 0; w < N_WORDS; w++) begin
            hi = 8'($urandom);
            lo = 8'($urandom);
            image[waddr_t'(w)] = {hi, lo};
            send_byte(HEADER_LEN + 2 * w, hi);
            send_byte(HEADER_LEN + 2 * w + 1, lo);
        end
        @(posedge clk);
        #5;
        downloading = 1'b0;
        do begin
            @(posedge clk);
            #5;
        end while (dwnld_busy);
        compare("write count", 16'(N_WORDS), 16'(i_sdram.wr_count));
        for (int w = 0; w < N_WORDS; w++) begin
            compare($sformatf("sdram word %0d", w), image[waddr_t'(w)],
                    i_sdram.peek(waddr_t'(w)));
        end

        for (int i = 0; i < N_READS; i++) begin
            read_slot(0);
            read_slot(1);
        end
        for (int i = 0; i < N_READS; i++) begin
            read_slot(2);
            read_slot(3);
        end

        // All four slots compete for the port
        single_reader = 1'b0;
        fork
            repeat (N_READS) read_slot(0);
            repeat (N_READS) read_slot(1);
            repeat (N_READS) read_slot(2);
            repeat (N_READS) read_slot(3);
        join
        for (int s = 0; s < 4; s++) begin
            recheck_cached(s);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin
        repeat (16 + N_OPS * 64) @(posedge clk);
        $display("Timeout: the DUT did not finish the test sequence in time");
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule
